// ==== include/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Word-address width of the memory behind the core port
`define RV_MEM_AW 10

`endif

// ==== src/rv_core_pkg.sv ====
`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]          word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB
    } ctrl_state_e;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        K_ALU_R,
        K_ALU_I,
        K_LUI,
        K_LOAD,
        K_STORE,
        K_BRANCH,
        K_JAL,
        K_ILLEGAL
    } instr_kind_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    typedef struct packed {
        instr_kind_e kind;
        alu_op_e     alu_op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        word_t       imm;
        logic        use_imm;
        logic        br_ne;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        word_t    pc;
        word_t    instr;
        reg_idx_t rd;
        logic     rd_we;
        word_t    rd_wdata;
        logic     mem_we;
        word_t    mem_addr;
        word_t    mem_wdata;
    } retire_t;

endpackage

// ==== src/rv_core_ctrl.sv ====
`timescale 1ns/1ps

module rv_core_ctrl
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  instr_kind_e kind_i,
    input  reg_idx_t    rd_i,
    input  logic        mem_ack_i,
    output logic        fetch_req_o,
    output logic        data_req_o,
    output logic        data_we_o,
    output logic        ir_load_o,
    output logic        pc_load_o,
    output logic        rf_we_o,
    output logic        retire_valid_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        boot_q;
    logic        data_done_q;
    logic        is_mem;
    logic        writes_rd;

    assign is_mem    = (kind_i == K_LOAD) || (kind_i == K_STORE);
    assign writes_rd = (kind_i == K_ALU_R) || (kind_i == K_ALU_I) || (kind_i == K_LUI) ||
                       (kind_i == K_LOAD)  || (kind_i == K_JAL);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= S_FETCH;
            boot_q      <= 1'b1;
            data_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            boot_q      <= 1'b0;
            // Load data sits in the port register one cycle before writeback
            data_done_q <= (state_q == S_MEM) && mem_ack_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_FETCH:  if (mem_ack_i) state_d = S_DECODE;
            S_DECODE: state_d = S_EXEC;
            S_EXEC:   state_d = is_mem ? S_MEM : S_WB;
            S_MEM:    if (data_done_q) state_d = S_WB;
            S_WB:     state_d = S_FETCH;
            default:  state_d = S_FETCH;
        endcase
    end

    // Next fetch is issued from writeback so the request is up on entry to S_FETCH
    assign fetch_req_o = boot_q || (state_q == S_WB);

    // Data request issued in S_EXEC while the ALU holds the address
    assign data_req_o = (state_q == S_EXEC) && is_mem;
    assign data_we_o  = (state_q == S_EXEC) && (kind_i == K_STORE);

    assign ir_load_o = (state_q == S_FETCH) && mem_ack_i;

    assign pc_load_o      = (state_q == S_WB);
    assign rf_we_o        = (state_q == S_WB) && writes_rd && (rd_i != '0);
    assign retire_valid_o = (state_q == S_WB);

endmodule

// ==== src/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_fetch
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        ir_load_i,
    input  logic        pc_load_i,
    input  word_t       mem_rdata_i,
    input  instr_kind_e kind_i,
    input  word_t       imm_i,
    input  logic        take_branch_i,
    output word_t       pc_o,
    output word_t       instr_o,
    output word_t       link_o,
    output word_t       fetch_addr_o
);

    word_t pc_q;
    word_t ir_q;
    word_t pc_next;
    logic  redirect;

    assign link_o = pc_q + `RV_XLEN'd4;

    // JAL always redirects, branches only when the condition holds
    assign redirect = (kind_i == K_JAL) || ((kind_i == K_BRANCH) && take_branch_i);
    assign pc_next  = redirect ? (pc_q + imm_i) : link_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RV_RESET_PC;
        end else if (pc_load_i) begin
            pc_q <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load_i) begin
            ir_q <= mem_rdata_i;
        end
    end

    // In writeback the next fetch already targets the updated PC
    assign fetch_addr_o = pc_load_i ? pc_next : pc_q;

    assign pc_o    = pc_q;
    assign instr_o = ir_q;

endmodule

// ==== src/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_decoder
    import rv_core_pkg::*;
(
    input  word_t    instr_i,
    output decoded_t dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_b_type;
    word_t      imm_u_type;
    word_t      imm_j_type;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};

    always_comb begin
        dec_o         = '0;
        dec_o.kind    = K_ILLEGAL;
        dec_o.alu_op  = ALU_ADD;
        dec_o.rd      = instr_i[11:7];
        dec_o.rs1     = instr_i[19:15];
        dec_o.rs2     = instr_i[24:20];
        dec_o.br_ne   = funct3[0];

        case (opcode)
            OPC_OP: begin
                dec_o.kind = K_ALU_R;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: dec_o.alu_op = ALU_SLT;
                    default:              dec_o.kind   = K_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                // Only ADDI in this subset
                if (funct3 == 3'b000) begin
                    dec_o.kind    = K_ALU_I;
                    dec_o.imm     = imm_i_type;
                    dec_o.use_imm = 1'b1;
                end
            end
            OPC_LUI: begin
                dec_o.kind    = K_LUI;
                dec_o.alu_op  = ALU_PASSB;
                dec_o.imm     = imm_u_type;
                dec_o.use_imm = 1'b1;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_o.kind    = K_LOAD;
                    dec_o.imm     = imm_i_type;
                    dec_o.use_imm = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_o.kind    = K_STORE;
                    dec_o.imm     = imm_s_type;
                    dec_o.use_imm = 1'b1;
                end
            end
            OPC_BRANCH: begin
                // BEQ and BNE compare rs1 against rs2, the immediate is the offset
                if (funct3[2:1] == 2'b00) begin
                    dec_o.kind = K_BRANCH;
                    dec_o.imm  = imm_b_type;
                end
            end
            OPC_JAL: begin
                dec_o.kind = K_JAL;
                dec_o.imm  = imm_j_type;
            end
            default: dec_o.kind = K_ILLEGAL;
        endcase

        // Kinds that write nothing report rd as x0
        if (dec_o.kind == K_STORE || dec_o.kind == K_BRANCH || dec_o.kind == K_ILLEGAL) begin
            dec_o.rd = '0;
        end
    end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     we_i,
    input  word_t    wdata_i,
    output word_t    rdata1_o,
    output word_t    rdata2_o
);

    word_t regs_q [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= wdata_i;
        end
    end

    // x0 is cleared by reset and never written
    assign rdata1_o = regs_q[rs1_i];
    assign rdata2_o = regs_q[rs2_i];

endmodule

// ==== src/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_alu
    import rv_core_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o,
    output logic    eq_o
);

    logic less_signed;

    assign less_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD:   result_o = a_i + b_i;
            ALU_SUB:   result_o = a_i - b_i;
            ALU_AND:   result_o = a_i & b_i;
            ALU_OR:    result_o = a_i | b_i;
            ALU_XOR:   result_o = a_i ^ b_i;
            ALU_SLT:   result_o = {{(`RV_XLEN-1){1'b0}}, less_signed};
            ALU_PASSB: result_o = b_i;
            default:   result_o = a_i + b_i;
        endcase
    end

    // Branch compare flag
    assign eq_o = (a_i == b_i);

endmodule

// ==== src/rv_mem_port.sv ====
`timescale 1ns/1ps

module rv_mem_port
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     fetch_req_i,
    input  logic     data_req_i,
    input  logic     data_we_i,
    input  word_t    pc_i,
    input  word_t    addr_i,
    input  word_t    store_data_i,
    input  logic     mem_ack_i,
    input  word_t    mem_rdata_i,
    output logic     mem_req_o,
    output mem_req_t mem_o,
    output word_t    load_data_o
);

    logic     req_q;
    logic     is_data_q;
    logic     start;
    mem_req_t req_d;
    mem_req_t req_hold_q;
    word_t    load_q;

    // A new request is only taken while the port is idle
    assign start = !req_q && (fetch_req_i || data_req_i);

    always_comb begin
        req_d.addr  = data_req_i ? addr_i : pc_i;
        req_d.wdata = data_req_i ? store_data_i : '0;
        req_d.we    = data_req_i && data_we_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            req_q <= 1'b0;
        end else if (req_q) begin
            if (mem_ack_i) begin
                req_q <= 1'b0;
            end
        end else if (start) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_hold_q <= req_d;
            is_data_q  <= data_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q && mem_ack_i && is_data_q && !req_hold_q.we) begin
            load_q <= mem_rdata_i;
        end
    end

    assign mem_req_o   = req_q;
    assign mem_o       = req_hold_q;
    assign load_data_o = load_q;

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    output logic     mem_req_o,
    output mem_req_t mem_o,
    input  logic     mem_ack_i,
    input  word_t    mem_rdata_i,
    output logic     retire_valid_o,
    output retire_t  retire_o
);

    logic     fetch_req;
    logic     data_req;
    logic     data_we;
    logic     ir_load;
    logic     pc_load;
    logic     rf_we;
    logic     take_branch;
    logic     alu_eq;
    word_t    pc;
    word_t    instr;
    word_t    link;
    word_t    fetch_addr;
    word_t    rdata1;
    word_t    rdata2;
    word_t    alu_b;
    word_t    alu_result;
    word_t    load_data;
    word_t    wb_data;
    decoded_t dec;

    rv_core_ctrl rv_core_ctrl_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .kind_i         (dec.kind),
        .rd_i           (dec.rd),
        .mem_ack_i      (mem_ack_i),
        .fetch_req_o    (fetch_req),
        .data_req_o     (data_req),
        .data_we_o      (data_we),
        .ir_load_o      (ir_load),
        .pc_load_o      (pc_load),
        .rf_we_o        (rf_we),
        .retire_valid_o (retire_valid_o)
    );

    rv_fetch rv_fetch_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .ir_load_i     (ir_load),
        .pc_load_i     (pc_load),
        .mem_rdata_i   (mem_rdata_i),
        .kind_i        (dec.kind),
        .imm_i         (dec.imm),
        .take_branch_i (take_branch),
        .pc_o          (pc),
        .instr_o       (instr),
        .link_o        (link),
        .fetch_addr_o  (fetch_addr)
    );

    rv_decoder rv_decoder_inst (
        .instr_i (instr),
        .dec_o   (dec)
    );

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .rs1_i    (dec.rs1),
        .rs2_i    (dec.rs2),
        .rd_i     (dec.rd),
        .we_i     (rf_we),
        .wdata_i  (wb_data),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    assign alu_b = dec.use_imm ? dec.imm : rdata2;

    rv_alu rv_alu_inst (
        .op_i     (dec.alu_op),
        .a_i      (rdata1),
        .b_i      (alu_b),
        .result_o (alu_result),
        .eq_o     (alu_eq)
    );

    // BNE inverts the equality flag, fetch qualifies it with the kind
    assign take_branch = alu_eq ^ dec.br_ne;

    rv_mem_port rv_mem_port_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_req_i  (fetch_req),
        .data_req_i   (data_req),
        .data_we_i    (data_we),
        .pc_i         (fetch_addr),
        .addr_i       (alu_result),
        .store_data_i (rdata2),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_req_o    (mem_req_o),
        .mem_o        (mem_o),
        .load_data_o  (load_data)
    );

    // Writeback source
    always_comb begin
        case (dec.kind)
            K_LOAD:  wb_data = load_data;
            K_JAL:   wb_data = link;
            default: wb_data = alu_result;
        endcase
    end

    // Record is read in S_WB, before the PC and IR move on
    always_comb begin
        retire_o.pc        = pc;
        retire_o.instr     = instr;
        retire_o.rd        = dec.rd;
        retire_o.rd_we     = rf_we;
        retire_o.rd_wdata  = wb_data;
        retire_o.mem_we    = (dec.kind == K_STORE);
        retire_o.mem_addr  = alu_result;
        retire_o.mem_wdata = rdata2;
    end

endmodule

// ==== tb/rv_core_assert.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_assert
    import rv_core_pkg::*;
(
    input logic     clk,
    input logic     reset_i,
    input logic     mem_req_i,
    input mem_req_t mem_i,
    input logic     mem_ack_i,
    input logic     retire_valid_i,
    input logic     rf_we_i,
    input reg_idx_t rd_i
);

    int req_fail_cnt = 0;
    int retire_fail_cnt = 0;
    int rf_fail_cnt = 0;

    // Request level holds with a stable payload until acked
    req_held: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_i))
        else begin
            req_fail_cnt = req_fail_cnt + 1;
            $error("Memory request dropped or changed before its ack");
        end

    retire_single: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid_i |=> !retire_valid_i)
        else begin
            retire_fail_cnt = retire_fail_cnt + 1;
            $error("Retire strobe high two cycles in a row");
        end

    // Destination field taken straight from the instruction register
    rf_no_x0: assert property (@(posedge clk) disable iff (reset_i)
        rf_we_i |-> rd_i != '0)
        else begin
            rf_fail_cnt = rf_fail_cnt + 1;
            $error("Register file written with rd zero");
        end

endmodule

bind rv_core_top rv_core_assert rv_core_assert_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .mem_req_i      (mem_req_o),
    .mem_i          (mem_o),
    .mem_ack_i      (mem_ack_i),
    .retire_valid_i (retire_valid_o),
    .rf_we_i        (rf_we),
    .rd_i           (instr[11:7])
);

// ==== tb/rv_core_checker.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_checker
    import rv_core_pkg::*;
#(
    parameter int N_RETIRES = 40,
    parameter int MEM_WORDS = 1024
) (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    mem_req_i,
    input  logic    mem_ack_i,
    input  logic    retire_valid_i,
    input  retire_t retire_i,
    input  word_t   image_i [MEM_WORDS],
    output logic    done_o,
    output int      value_errs_o,
    output int      timing_errs_o
);

    // Instruction-set model state
    word_t   m_mem [MEM_WORDS];
    word_t   m_regs [`RV_NREGS];
    word_t   m_pc;
    logic    done = 1'b0;
    int      value_errs = 0;
    int      timing_errs = 0;
    int      cycle;
    int      ack_cycle;
    int      retired;
    logic    fetch_pending;
    logic    is_mem;
    retire_t exp;

    // Steps one instruction of the model and returns its expected record
    function automatic retire_t ref_step();
        retire_t    r;
        word_t      ins;
        word_t      rs1v;
        word_t      rs2v;
        word_t      val;
        word_t      ea;
        word_t      next_pc;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic       wr;
        ins     = m_mem[m_pc[`RV_MEM_AW+1:2]];
        opc     = ins[6:0];
        f3      = ins[14:12];
        f7      = ins[31:25];
        rd      = ins[11:7];
        rs1v    = m_regs[ins[19:15]];
        rs2v    = m_regs[ins[24:20]];
        val     = '0;
        wr      = 1'b0;
        next_pc = m_pc + 32'd4;
        r       = '0;
        r.pc    = m_pc;
        r.instr = ins;
        case (opc)
            7'h33: begin
                wr = 1'b1;
                case ({f7, f3})
                    10'b0000000_000: val = rs1v + rs2v;
                    10'b0100000_000: val = rs1v - rs2v;
                    10'b0000000_111: val = rs1v & rs2v;
                    10'b0000000_110: val = rs1v | rs2v;
                    10'b0000000_100: val = rs1v ^ rs2v;
                    10'b0000000_010: val = ($signed(rs1v) < $signed(rs2v)) ? 32'd1 : 32'd0;
                    default:         wr  = 1'b0;
                endcase
            end
            7'h13: if (f3 == 3'b000) begin
                wr  = 1'b1;
                val = rs1v + {{20{ins[31]}}, ins[31:20]};
            end
            7'h37: begin
                wr  = 1'b1;
                val = {ins[31:12], 12'b0};
            end
            7'h03: if (f3 == 3'b010) begin
                ea  = rs1v + {{20{ins[31]}}, ins[31:20]};
                wr  = 1'b1;
                val = m_mem[ea[`RV_MEM_AW+1:2]];
            end
            7'h23: if (f3 == 3'b010) begin
                ea          = rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                r.mem_we    = 1'b1;
                r.mem_addr  = ea;
                r.mem_wdata = rs2v;
                m_mem[ea[`RV_MEM_AW+1:2]] = rs2v;
            end
            7'h63: if (f3[2:1] == 2'b00) begin
                if ((rs1v == rs2v) != f3[0]) begin
                    next_pc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'h6f: begin
                wr      = 1'b1;
                val     = m_pc + 32'd4;
                next_pc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        // Non-writing kinds report x0
        r.rd = wr ? rd : 5'd0;
        if (wr && rd != 5'd0) begin
            r.rd_we    = 1'b1;
            r.rd_wdata = val;
            m_regs[rd] = val;
        end
        m_pc = next_pc;
        return r;
    endfunction

    task automatic check_field(input string name, input word_t expv, input word_t got);
        if (expv !== got) begin
            value_errs++;
            $display("FAIL %0t: pc %h %s expected %h got %h", $time, exp.pc, name, expv, got);
        end
    endtask

    always @(negedge clk) begin
        if (reset_i) begin
            if (mem_req_i || retire_valid_i) begin
                timing_errs++;
                $display("Error at %0t: memory request or retire strobe active in reset",
                         $time);
            end
            m_mem = image_i;
            for (int i = 0; i < `RV_NREGS; i++) begin
                m_regs[i] = '0;
            end
            m_pc          = `RV_RESET_PC;
            cycle         = 0;
            ack_cycle     = 0;
            retired       = 0;
            fetch_pending = 1'b1;
        end else begin
            cycle++;
            if (mem_ack_i && fetch_pending) begin
                ack_cycle     = cycle;
                fetch_pending = 1'b0;
            end
            if (retire_valid_i && !done) begin
                exp    = ref_step();
                is_mem = (exp.instr[6:0] == 7'h03 || exp.instr[6:0] == 7'h23) &&
                         (exp.instr[14:12] == 3'b010);
                check_field("pc", exp.pc, retire_i.pc);
                check_field("instr", exp.instr, retire_i.instr);
                check_field("rd", {27'b0, exp.rd}, {27'b0, retire_i.rd});
                check_field("rd_we", {31'b0, exp.rd_we}, {31'b0, retire_i.rd_we});
                if (exp.rd_we) begin
                    check_field("rd_wdata", exp.rd_wdata, retire_i.rd_wdata);
                end
                check_field("mem_we", {31'b0, exp.mem_we}, {31'b0, retire_i.mem_we});
                if (exp.mem_we) begin
                    check_field("mem_addr", exp.mem_addr, retire_i.mem_addr);
                    check_field("mem_wdata", exp.mem_wdata, retire_i.mem_wdata);
                end
                if (!is_mem && (cycle - ack_cycle) != 3) begin
                    timing_errs++;
                    $display("Error at %0t: instruction at pc %h retired %0d cycles after %s",
                             $time, exp.pc, cycle - ack_cycle, "its fetch ack, not 3");
                end
                fetch_pending = 1'b1;
                retired++;
                if (retired == N_RETIRES) begin
                    done = 1'b1;
                end
            end
        end
    end

    assign done_o        = done;
    assign value_errs_o  = value_errs;
    assign timing_errs_o = timing_errs;

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_top
    import rv_core_pkg::*;
();

    localparam int MEM_WORDS    = 1 << `RV_MEM_AW;
    localparam int CLK_PERIOD   = 40;
    localparam int N_RETIRES    = 40;
    // Fetch and data wait up to 4 cycles each, plus decode, exec, mem and writeback
    localparam int WORST_CYCLES = 16;
    localparam int LIMIT_NS     = (N_RETIRES * WORST_CYCLES + 8 + 40) * CLK_PERIOD;
    localparam logic [31:0] LCG_SEED = 32'hd1dca5f1;

    logic     clk = 1'b0;
    logic     reset_i;
    logic     mem_req_o;
    mem_req_t mem_o;
    logic     mem_ack_i;
    word_t    mem_rdata_i;
    logic     retire_valid_o;
    retire_t  retire_o;
    word_t    mem [MEM_WORDS];
    logic     chk_done;
    int       value_errs;
    int       timing_errs;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core_top rv_core_top_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .mem_req_o      (mem_req_o),
        .mem_o          (mem_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    rv_core_checker #(
        .N_RETIRES (N_RETIRES),
        .MEM_WORDS (MEM_WORDS)
    ) rv_core_checker_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .mem_req_i      (mem_req_o),
        .mem_ack_i      (mem_ack_i),
        .retire_valid_i (retire_valid_o),
        .retire_i       (retire_o),
        .image_i        (mem),
        .done_o         (chk_done),
        .value_errs_o   (value_errs),
        .timing_errs_o  (timing_errs)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Instruction encoders
    function automatic word_t r_type(input logic [31:0] f7, input logic [31:0] rs2,
                                     input logic [31:0] rs1, input logic [31:0] f3,
                                     input logic [31:0] rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [31:0] imm, input logic [31:0] rs1,
                                     input logic [31:0] f3, input logic [31:0] rd,
                                     input logic [31:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(input logic [31:0] imm, input logic [31:0] rs2,
                                     input logic [31:0] rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [31:0] imm, input logic [31:0] rs2,
                                     input logic [31:0] rs1, input logic [31:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [31:0] imm20, input logic [31:0] rd);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t j_type(input logic [31:0] imm, input logic [31:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hA5A5_0000 ^ i;
        end
        mem[0]  = i_type(5, 0, 0, 1, 32'h13);
        mem[1]  = i_type(-3, 0, 0, 2, 32'h13);
        mem[2]  = r_type(0, 2, 1, 0, 3);
        mem[3]  = r_type(32'h20, 1, 2, 0, 4);
        mem[4]  = r_type(0, 2, 1, 7, 5);
        mem[5]  = r_type(0, 2, 1, 6, 6);
        mem[6]  = r_type(0, 2, 1, 4, 7);
        mem[7]  = r_type(0, 1, 2, 2, 8);
        mem[8]  = r_type(0, 2, 1, 2, 9);
        mem[9]  = u_type(32'h12345, 10);
        mem[10] = i_type(32'h678, 10, 0, 10, 32'h13);
        mem[11] = i_type(32'h400, 0, 0, 11, 32'h13);
        // Store then load back through the data area at 0x400
        mem[12] = s_type(0, 10, 11);
        mem[13] = s_type(4, 4, 11);
        mem[14] = i_type(0, 11, 2, 12, 32'h03);
        mem[15] = i_type(4, 11, 2, 13, 32'h03);
        mem[16] = i_type(8, 11, 2, 14, 32'h03);
        mem[17] = i_type(7, 0, 0, 0, 32'h13);
        mem[18] = r_type(0, 0, 0, 0, 15);
        mem[19] = 32'h0000_0000;
        mem[20] = 32'hFFFF_FFFF;
        mem[21] = b_type(8, 2, 1, 0);
        mem[22] = b_type(8, 2, 1, 1);
        mem[23] = i_type(1, 0, 0, 16, 32'h13);
        mem[24] = b_type(8, 10, 12, 0);
        mem[25] = i_type(2, 0, 0, 16, 32'h13);
        mem[26] = b_type(8, 3, 3, 1);
        mem[27] = j_type(12, 1);
        mem[28] = i_type(9, 0, 0, 17, 32'h13);
        mem[29] = i_type(10, 0, 0, 17, 32'h13);
        mem[30] = r_type(0, 13, 1, 0, 18);
        mem[31] = j_type(8, 19);
        mem[32] = i_type(11, 0, 0, 17, 32'h13);
        mem[33] = i_type(-4, 11, 2, 20, 32'h03);
        mem[34] = s_type(12, 18, 11);
        mem[35] = i_type(12, 11, 2, 21, 32'h03);
        mem[36] = r_type(0, 18, 21, 4, 22);
        mem[37] = r_type(0, 0, 4, 2, 23);
        mem[38] = r_type(32'h20, 1, 0, 0, 24);
        mem[39] = i_type(-1, 24, 0, 25, 32'h13);
        mem[40] = j_type(0, 0);
        // Preloaded data words
        mem[32'hFF]  = 32'h1357_9BDF;
        mem[32'h102] = 32'hCAFE_F00D;
    endtask

    // Memory model that acks after 0 to 3 idle cycles
    initial begin : memory_model
        logic [31:0] lcg_state;
        logic [1:0]  delay;
        logic        pending;
        logic [`RV_MEM_AW-1:0] idx;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        lcg_state   = LCG_SEED;
        delay       = 2'd0;
        pending     = 1'b0;
        load_program();
        forever begin
            @(posedge clk);
            #2;
            if (mem_ack_i) begin
                // Port dropped the request on this edge
                mem_ack_i = 1'b0;
            end else if (mem_req_o) begin
                if (!pending) begin
                    lcg_state = lcg_next(lcg_state);
                    delay     = lcg_state[17:16];
                    pending   = 1'b1;
                end
                if (delay == 2'd0) begin
                    idx = mem_o.addr[`RV_MEM_AW+1:2];
                    if (mem_o.we) begin
                        mem[idx] = mem_o.wdata;
                    end
                    mem_rdata_i = mem[idx];
                    mem_ack_i   = 1'b1;
                    pending     = 1'b0;
                end else begin
                    delay = delay - 2'd1;
                end
            end
        end
    end

    initial begin : main
        int assert_fails;
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;
        wait (chk_done);
        @(posedge clk);
        assert_fails = rv_core_top_inst.rv_core_assert_inst.req_fail_cnt +
                       rv_core_top_inst.rv_core_assert_inst.retire_fail_cnt +
                       rv_core_top_inst.rv_core_assert_inst.rf_fail_cnt;
        $display("Errors: value %0d, timing %0d, assertion %0d", value_errs, timing_errs,
                 assert_fails);
        if (value_errs == 0 && timing_errs == 0 && assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("Watchdog expired at %0t: the core stopped retiring instructions", $time);
        $display("test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
src/rv_core_pkg.sv
src/rv_core_ctrl.sv
src/rv_fetch.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_mem_port.sv
src/rv_core_top.sv
tb/rv_core_assert.sv
tb/rv_core_checker.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run the core testbench

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_top --Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Keep running past assertion errors so the closing report is printed
./obj_dir/tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
